// ==== cpu8.f ====
+incdir+include
verilog/cpu8_pkg.sv
verilog/cpu_sequencer.sv
verilog/address_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/cpu_top.sv
sim/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# compile and run cpu_tb with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu8.f -o cpu_tb_sim \
	&& ./obj_dir/cpu_tb_sim | tee sim.log \
	&& grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// ==== include/cpu_tb_program.svh ====
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

task automatic emit(byte_t b);
	mem[asm_pc] = b;
	asm_pc = asm_pc + 16'd1;
endtask

function automatic addr_t next_result();
	next_result = res_ptr;
	res_ptr = res_ptr + 16'd1;
endfunction

task automatic asm_mvi(reg_sel_t r, byte_t v);
	emit(OP_MVI | {2'b00, r, 3'b000});
	emit(v);
	model_reg[r] = v;
	n_instr++;
endtask

task automatic asm_mov(reg_sel_t d, reg_sel_t s);
	emit({2'b01, d, s});
	model_reg[d] = model_reg[s];
	n_instr++;
endtask

task automatic asm_sta(addr_t a);
	emit(OP_STA);
	emit(a[7:0]);
	emit(a[15:8]);
	exp_addr.push_back(a);
	exp_data.push_back(model_reg[REG_A]);
	n_instr++;
endtask

// carry is a borrow for the subtracting ops
task automatic model_alu(alu_op_t op, byte_t b);
	int a;
	int r;
	byte_t res;
	a = int'(model_reg[REG_A]);
	case (op)
		ALU_ADD: r = a + int'(b);
		ALU_ADC: r = a + int'(b) + int'(flag_c);
		ALU_SUB, ALU_CMP: r = a - int'(b);
		ALU_SBB: r = a - int'(b) - int'(flag_c);
		ALU_AND: r = a & int'(b);
		ALU_XOR: r = a ^ int'(b);
		default: r = a | int'(b);
	endcase
	res = r[7:0];
	flag_c = (r > 255) || (r < 0);               // logical ops stay in range
	flag_s = res[7];
	flag_z = res == 8'h00;
	flag_p = ($countones(res) % 2) == 0;
	if (op != ALU_CMP)
		model_reg[REG_A] = res;
endtask

task automatic asm_alu(alu_op_t op, reg_sel_t s);
	emit({2'b10, op, s});
	model_alu(op, model_reg[s]);
	n_instr++;
endtask

task automatic asm_alui(alu_op_t op, byte_t v);
	emit(OP_ALUI | {2'b00, op, 3'b000});
	emit(v);
	model_alu(op, v);
	n_instr++;
endtask

function automatic bit cond_model(logic [2:0] cc);
	case (cc)
		3'd0: return !flag_z;
		3'd1: return flag_z;
		3'd2: return !flag_c;
		3'd3: return flag_c;
		3'd4: return !flag_p;
		3'd5: return flag_p;
		3'd6: return !flag_s;
		default: return flag_s;
	endcase
endfunction

// jump over an MVI A / STA pair that stores a marker
task automatic asm_jump(byte_t opcode, bit taken);
	addr_t target;
	addr_t marker_addr;
	byte_t marker;
	marker_addr = next_result();
	marker = byte_t'($random(seed));
	target = asm_pc + 16'd8;
	emit(opcode);
	emit(target[7:0]);
	emit(target[15:8]);
	emit(OP_MVI | {2'b00, REG_A, 3'b000});
	emit(marker);
	emit(OP_STA);
	emit(marker_addr[7:0]);
	emit(marker_addr[15:8]);
	n_instr += 3;
	if (taken) begin
		skipped.push_back(marker_addr);
	end else begin
		model_reg[REG_A] = marker;
		exp_addr.push_back(marker_addr);
		exp_data.push_back(marker);
	end
endtask

task automatic build_program();
	asm_pc = '0;
	res_ptr = 16'h8000;                          // results sit well above the code
	n_instr = 0;
	flag_s = 1'b0;
	flag_z = 1'b0;
	flag_p = 1'b0;
	flag_c = 1'b0;
	for (int i = 0; i < 8; i++)
		model_reg[i] = '0;
	for (int i = 0; i < 8; i++) begin
		if (i != 6)
			asm_mvi(reg_sel_t'(i), byte_t'($random(seed)));
	end
	asm_mov(3'd1, 3'd0);                         // B -> C -> E -> A
	asm_mov(3'd3, 3'd1);
	asm_mov(REG_A, 3'd3);
	asm_sta(next_result());
	asm_mov(3'd5, 3'd4);                         // H -> L -> A
	asm_mov(REG_A, 3'd5);
	asm_sta(next_result());
	asm_mvi(REG_A, byte_t'($random(seed)));
	for (int op = 0; op < 8; op++) begin
		asm_alu(alu_op_t'(op), reg_sel_t'(op % 6));
		asm_sta(next_result());
		asm_alui(alu_op_t'(op), byte_t'($random(seed)));
		asm_sta(next_result());
	end
	for (int k = 0; k < 24; k++) begin
		asm_mvi(REG_A, byte_t'($random(seed)));
		asm_alui(alu_op_t'($random(seed)), byte_t'($random(seed)));
		asm_jump(OP_JCC | {2'b00, 3'(k % 8), 3'b000}, cond_model(3'(k % 8)));
	end
	asm_jump(OP_JMP, 1'b1);
	emit(OP_HLT);
	n_instr++;
endtask

`endif

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
module cpu_tb import cpu8_pkg::*; ();

	localparam int CLK_PERIOD = 100;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic memory_read;
	logic memory_write;
	addr_t memory_addr;
	byte_t memory_wdata;
	byte_t memory_rdata = '0;
	logic memory_done = 1'b0;
	logic cpu_halted;

	byte_t mem [0:65535];
	integer seed = 79;
	addr_t asm_pc;
	addr_t res_ptr;
	int n_instr;
	byte_t model_reg [0:7];
	logic flag_s, flag_z, flag_p, flag_c;
	addr_t exp_addr [$];
	byte_t exp_data [$];
	addr_t skipped [$];
	byte_t store_data [int];
	int errors = 0;
	int writes = 0;
	bit in_cycle = 1'b0;
	int wait_left = 0;
	bit waiting = 1'b0;
	bit halt_seen = 1'b0;
	bit first_seen = 1'b0;
	logic prev_read;
	logic prev_write;
	addr_t prev_addr;
	byte_t prev_wdata;

	`include "cpu_tb_program.svh"

	cpu_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.memory_read(memory_read),
		.memory_write(memory_write),
		.memory_addr(memory_addr),
		.memory_wdata(memory_wdata),
		.memory_rdata(memory_rdata),
		.memory_done(memory_done),
		.cpu_halted(cpu_halted)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic expect_equal(string name, int got, int exp);
		assert (got == exp) else begin
			errors++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	// memory with 0 to 3 wait states per bus cycle
	always @(posedge clk) begin
		#1;
		if (memory_done)
			in_cycle = 1'b0;
		if (!in_cycle && (memory_read || memory_write)) begin
			in_cycle = 1'b1;
			wait_left = $unsigned($random(seed)) % 4;
		end
		if (in_cycle && wait_left == 0) begin
			memory_done = 1'b1;
			if (memory_read)
				memory_rdata = mem[memory_addr];
		end else begin
			memory_done = 1'b0;
			if (in_cycle)
				wait_left--;
		end
	end

	// bus checks in the middle of the cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (!first_seen) begin
				first_seen = 1'b1;
				assert (memory_read && !memory_write && !cpu_halted) else begin
					errors++;
					$display("first cycle after reset is not a plain read with the CPU running");
				end
				expect_equal("memory_addr", memory_addr, 16'h0000);
			end
			if (waiting) begin
				expect_equal("memory_read", memory_read, prev_read);
				expect_equal("memory_write", memory_write, prev_write);
				expect_equal("memory_addr", memory_addr, prev_addr);
				if (memory_write)
					expect_equal("memory_wdata", memory_wdata, prev_wdata);
			end
			if (memory_write && memory_done) begin
				assert (!store_data.exists(int'(memory_addr))) else begin
					errors++;
					$display("address %h was stored to a second time", memory_addr);
				end
				store_data[int'(memory_addr)] = memory_wdata;
				writes++;
			end
			if (halt_seen) begin
				assert (cpu_halted && !memory_read && !memory_write) else begin
					errors++;
					$display("bus activity or cpu_halted low after HLT at %0t ns", $time);
				end
			end
			if (cpu_halted)
				halt_seen = 1'b1;
			waiting = (memory_read || memory_write) && !memory_done;
			prev_read = memory_read;
			prev_write = memory_write;
			prev_addr = memory_addr;
			prev_wdata = memory_wdata;
		end
	end

	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = byte_t'(i ^ (i >> 8) ^ 8'h5a);
		build_program();
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wait (cpu_halted);
		repeat (10) @(posedge clk);
		foreach (exp_addr[i]) begin
			assert (store_data.exists(int'(exp_addr[i]))) else begin
				errors++;
				$display("no store reached address %h", exp_addr[i]);
			end
			if (store_data.exists(int'(exp_addr[i])))
				expect_equal($sformatf("memory_wdata at %h", exp_addr[i]),
					store_data[int'(exp_addr[i])], exp_data[i]);
		end
		foreach (skipped[i]) begin
			assert (!store_data.exists(int'(skipped[i]))) else begin
				errors++;
				$display("marker at %h stored although its jump is taken", skipped[i]);
			end
		end
		assert (writes == exp_addr.size()) else begin
			errors++;
			$display("number of stores differs from the program");
		end
		$display("stores seen %0d, expected %0d, errors %0d", writes, exp_addr.size(), errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		#1;                                      // program is assembled at time zero
		#((n_instr * 5 * 4 + 50) * CLK_PERIOD);
		$display("timeout, the processor never reached HLT");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verilog/address_unit.sv ====
`timescale 1ns/1ps
module address_unit import cpu8_pkg::*; (
	input logic clk,
	input logic rst_n,
	input byte_t db,
	input db_sel_t db_dst,
	input logic pc_inc,
	input logic pc_jump,
	input logic addr_sel,
	output addr_t memory_addr
);

	addr_t pc;
	addr_t al;
	logic pc_load;

	// the high address byte arrives last and the low byte already sits in the latch
	assign pc_load = pc_jump && db_dst == DB_PC_HI;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (pc_load) begin
			pc <= {db, al[7:0]};
		end else if (pc_inc) begin
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al <= '0;
		end else begin
			if (db_dst == DB_AL_LO)
				al[7:0] <= db;
			if (db_dst == DB_AL_HI)
				al[15:8] <= db;
		end
	end

	assign memory_addr = addr_sel ? al : pc;

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
module alu import cpu8_pkg::*; (
	input logic clk,
	input logic rst_n,
	input byte_t acc,
	input byte_t operand,
	input alu_op_t alu_op,
	input logic flags_we,
	output byte_t alu_result,
	output psr_t psr
);

	logic carry_in;
	logic carry_out;
	psr_t psr_next;

	assign carry_in = psr[FLAG_C];

	always_comb begin
		carry_out = 1'b0;
		case (alu_op)
			ALU_ADD: {carry_out, alu_result} = {1'b0, acc} + {1'b0, operand};
			ALU_ADC: {carry_out, alu_result} = {1'b0, acc} + {1'b0, operand} + carry_in;
			ALU_SUB, ALU_CMP: begin
				{carry_out, alu_result} = {1'b0, acc} - {1'b0, operand};   // carry is borrow
			end
			ALU_SBB: {carry_out, alu_result} = {1'b0, acc} - {1'b0, operand} - carry_in;
			ALU_AND: alu_result = acc & operand;
			ALU_XOR: alu_result = acc ^ operand;
			ALU_OR: alu_result = acc | operand;
			default: alu_result = acc;
		endcase
	end

	always_comb begin
		psr_next = PSR_RESET;
		psr_next[FLAG_S] = alu_result[7];
		psr_next[FLAG_Z] = alu_result == '0;
		psr_next[FLAG_P] = ~^alu_result;         // even parity
		psr_next[FLAG_C] = carry_out;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			psr <= PSR_RESET;
		else if (flags_we)
			psr <= psr_next;
	end

endmodule

// ==== verilog/cpu8_pkg.sv ====
package cpu8_pkg;

	localparam int BYTE_W = 8;
	localparam int ADDR_W = 16;
	localparam int DB_SEL_W = 4;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [2:0] reg_sel_t;               // 8080 register code
	typedef logic [DB_SEL_W-1:0] db_sel_t;
	typedef logic [2:0] alu_op_t;                // instruction bits 5..3
	typedef logic [BYTE_W-1:0] psr_t;

	// register code 6 is the unsupported memory operand
	localparam reg_sel_t REG_M = 3'd6;
	localparam reg_sel_t REG_A = 3'd7;

	// internal data bus sources and destinations
	localparam db_sel_t DB_NONE = 4'h0;
	localparam db_sel_t DB_AL_LO = 4'h1;
	localparam db_sel_t DB_AL_HI = 4'h2;
	localparam db_sel_t DB_PC_HI = 4'h3;
	localparam db_sel_t DB_ALU = 4'h4;           // result as source, operand latch as dest
	localparam db_sel_t DB_MEM = 4'h5;
	localparam db_sel_t DB_A = {1'b1, REG_A};    // 8..f name the registers

	// flag byte layout
	localparam int FLAG_S = 7;
	localparam int FLAG_Z = 6;
	localparam int FLAG_P = 2;
	localparam int FLAG_C = 0;
	localparam psr_t PSR_RESET = 8'h02;          // bit 1 always reads one

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_ADC = 3'd1;
	localparam alu_op_t ALU_SUB = 3'd2;
	localparam alu_op_t ALU_SBB = 3'd3;
	localparam alu_op_t ALU_AND = 3'd4;
	localparam alu_op_t ALU_XOR = 3'd5;
	localparam alu_op_t ALU_OR = 3'd6;
	localparam alu_op_t ALU_CMP = 3'd7;

	// fixed opcodes
	localparam byte_t OP_HLT = 8'h76;
	localparam byte_t OP_JMP = 8'hc3;
	localparam byte_t OP_STA = 8'h32;

	// patterns compared after masking out bits 5..3
	localparam byte_t OP_FIELD_MASK = 8'h38;
	localparam byte_t OP_JCC = 8'hc2;
	localparam byte_t OP_MVI = 8'h06;
	localparam byte_t OP_ALUI = 8'hc6;

endpackage

// ==== verilog/cpu_sequencer.sv ====
`timescale 1ns/1ps
module cpu_sequencer import cpu8_pkg::*; (
	input logic clk,
	input logic rst_n,
	input byte_t memory_rdata,
	input logic memory_done,
	input psr_t psr,
	output logic memory_read,
	output logic memory_write,
	output logic addr_sel,
	output logic pc_inc,
	output logic pc_jump,
	output db_sel_t db_src,
	output db_sel_t db_dst,
	output alu_op_t alu_op,
	output logic flags_we,
	output logic cpu_halted
);

	typedef enum logic [3:0] {
		ST_FETCH, ST_DECODE, ST_MOVE, ST_IMM, ST_OPERAND,
		ST_EXEC, ST_ADDR_LO, ST_ADDR_HI, ST_STORE, ST_HALT
	} state_t;

	state_t state;
	state_t next_state;
	byte_t ir;
	reg_sel_t src_reg;
	reg_sel_t dst_reg;
	logic i_mov, i_mvi, i_alu, i_alui;
	logic i_jmp, i_jcc, i_sta, i_hlt;
	logic condition;
	logic step_done;
	db_sel_t dst_raw;
	logic inc_raw;
	logic jump_raw;
	logic flags_raw;

	assign src_reg = ir[2:0];
	assign dst_reg = ir[5:3];
	assign alu_op = ir[5:3];

	assign i_hlt = ir == OP_HLT;
	assign i_mov = ir[7:6] == 2'b01 && src_reg != REG_M && dst_reg != REG_M;
	assign i_mvi = (ir & ~OP_FIELD_MASK) == OP_MVI && dst_reg != REG_M;
	assign i_alu = ir[7:6] == 2'b10 && src_reg != REG_M;
	assign i_alui = (ir & ~OP_FIELD_MASK) == OP_ALUI;
	assign i_jmp = ir == OP_JMP;
	assign i_jcc = (ir & ~OP_FIELD_MASK) == OP_JCC;
	assign i_sta = ir == OP_STA;

	always_comb begin
		case (ir[5:3])
			3'd0: condition = !psr[FLAG_Z];      // nz
			3'd1: condition = psr[FLAG_Z];
			3'd2: condition = !psr[FLAG_C];      // nc
			3'd3: condition = psr[FLAG_C];
			3'd4: condition = !psr[FLAG_P];      // po
			3'd5: condition = psr[FLAG_P];
			3'd6: condition = !psr[FLAG_S];      // p
			default: condition = psr[FLAG_S];
		endcase
	end

	always_comb begin
		next_state = ST_FETCH;
		case (state)
			ST_FETCH: next_state = ST_DECODE;
			ST_DECODE: begin
				if (i_hlt)
					next_state = ST_HALT;
				else if (i_mov)
					next_state = ST_MOVE;
				else if (i_mvi)
					next_state = ST_IMM;
				else if (i_alu || i_alui)
					next_state = ST_OPERAND;
				else if (i_jmp || i_jcc || i_sta)
					next_state = ST_ADDR_LO;
			end
			ST_OPERAND: next_state = ST_EXEC;
			ST_ADDR_LO: next_state = ST_ADDR_HI;
			ST_ADDR_HI: next_state = i_sta ? ST_STORE : ST_FETCH;
			ST_HALT: next_state = ST_HALT;
			default: next_state = ST_FETCH;
		endcase
	end

	always_comb begin
		memory_read = 1'b0;
		memory_write = 1'b0;
		addr_sel = 1'b0;
		db_src = DB_NONE;
		dst_raw = DB_NONE;
		inc_raw = 1'b0;
		jump_raw = 1'b0;
		flags_raw = 1'b0;
		case (state)
			ST_FETCH: begin
				memory_read = 1'b1;
				db_src = DB_MEM;
				inc_raw = 1'b1;
			end
			ST_MOVE: begin
				db_src = {1'b1, src_reg};
				dst_raw = {1'b1, dst_reg};
			end
			ST_IMM: begin
				memory_read = 1'b1;
				db_src = DB_MEM;
				dst_raw = {1'b1, dst_reg};
				inc_raw = 1'b1;
			end
			ST_OPERAND: begin
				memory_read = i_alui;
				db_src = i_alui ? DB_MEM : {1'b1, src_reg};
				dst_raw = DB_ALU;
				inc_raw = i_alui;
			end
			ST_EXEC: begin
				db_src = DB_ALU;
				dst_raw = alu_op == ALU_CMP ? DB_NONE : DB_A;
				flags_raw = 1'b1;
			end
			ST_ADDR_LO: begin
				memory_read = 1'b1;
				db_src = DB_MEM;
				dst_raw = DB_AL_LO;
				inc_raw = 1'b1;
			end
			ST_ADDR_HI: begin
				memory_read = 1'b1;
				db_src = DB_MEM;
				inc_raw = 1'b1;
				if (i_sta) begin
					dst_raw = DB_AL_HI;
				end else if (i_jmp || condition) begin
					dst_raw = DB_PC_HI;
					jump_raw = 1'b1;
				end
			end
			ST_STORE: begin
				memory_write = 1'b1;
				addr_sel = 1'b1;                 // latched operand address
				db_src = DB_A;
			end
			default: begin
			end
		endcase
	end

	// a step without a strobe ends in its first clock
	assign step_done = !(memory_read || memory_write) || memory_done;

	assign db_dst = step_done ? dst_raw : DB_NONE;
	assign pc_inc = step_done && inc_raw;
	assign pc_jump = step_done && jump_raw;
	assign flags_we = step_done && flags_raw;
	assign cpu_halted = state == ST_HALT;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_FETCH;
			ir <= '0;
		end else if (step_done) begin
			state <= next_state;
			if (state == ST_FETCH)
				ir <= memory_rdata;
		end
	end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps
module cpu_top import cpu8_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic memory_read,
	output logic memory_write,
	output addr_t memory_addr,
	output byte_t memory_wdata,
	input byte_t memory_rdata,
	input logic memory_done,
	output logic cpu_halted
);

	db_sel_t db_src;
	db_sel_t db_dst;
	alu_op_t alu_op;
	logic flags_we;
	logic pc_inc;
	logic pc_jump;
	logic addr_sel;
	byte_t db;
	byte_t acc;
	byte_t operand;
	byte_t alu_result;
	psr_t psr;

	cpu_sequencer u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.memory_rdata(memory_rdata),
		.memory_done(memory_done),
		.psr(psr),
		.memory_read(memory_read),
		.memory_write(memory_write),
		.addr_sel(addr_sel),
		.pc_inc(pc_inc),
		.pc_jump(pc_jump),
		.db_src(db_src),
		.db_dst(db_dst),
		.alu_op(alu_op),
		.flags_we(flags_we),
		.cpu_halted(cpu_halted)
	);

	address_unit u_address_unit (
		.clk(clk),
		.rst_n(rst_n),
		.db(db),
		.db_dst(db_dst),
		.pc_inc(pc_inc),
		.pc_jump(pc_jump),
		.addr_sel(addr_sel),
		.memory_addr(memory_addr)
	);

	register_file u_register_file (
		.clk(clk),
		.rst_n(rst_n),
		.db_src(db_src),
		.db_dst(db_dst),
		.memory_rdata(memory_rdata),
		.alu_result(alu_result),
		.db(db),
		.acc(acc),
		.operand(operand)
	);

	alu u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.acc(acc),
		.operand(operand),
		.alu_op(alu_op),
		.flags_we(flags_we),
		.alu_result(alu_result),
		.psr(psr)
	);

	assign memory_wdata = db;                    // store data comes off the internal bus

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
module register_file import cpu8_pkg::*; (
	input logic clk,
	input logic rst_n,
	input db_sel_t db_src,
	input db_sel_t db_dst,
	input byte_t memory_rdata,
	input byte_t alu_result,
	output byte_t db,
	output byte_t acc,
	output byte_t operand
);

	byte_t regs [0:7];                           // slot 6 is never written
	reg_sel_t src_sel;
	reg_sel_t dst_sel;
	logic dst_is_reg;

	assign src_sel = db_src[2:0];
	assign dst_sel = db_dst[2:0];
	assign dst_is_reg = db_dst[3] && dst_sel != REG_M;

	always_comb begin
		case (db_src)
			DB_MEM: db = memory_rdata;
			DB_ALU: db = alu_result;
			default: db = db_src[3] ? regs[src_sel] : '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			operand <= '0;
		end else begin
			if (dst_is_reg)
				regs[dst_sel] <= db;
			if (db_dst == DB_ALU)
				operand <= db;                   // second alu input
		end
	end

	assign acc = regs[REG_A];

endmodule
